/* include/apu_defines.svh */
`ifndef APU_DEFINES_SVH
`define APU_DEFINES_SVH

// channel 1 register addresses
`define APU_NR10 3'd0
`define APU_NR11 3'd1
`define APU_NR12 3'd2
`define APU_NR13 3'd3
`define APU_NR14 3'd4

// bits that always read back as 1
`define APU_NR10_MASK 8'h80
`define APU_NR11_MASK 8'h3f
`define APU_NR12_MASK 8'h00
`define APU_NR13_MASK 8'hff
`define APU_NR14_MASK 8'hbf

// frame sequencer steps that clock the sweep and the envelope
`define APU_STEP_SWEEP_A 3'd2
`define APU_STEP_SWEEP_B 3'd6
`define APU_STEP_ENV     3'd7

`endif

/* verilog/apu_pkg.sv */
package apu_pkg;

	// CPU side register byte and address
	typedef logic [7:0] reg_data_t;
	typedef logic [2:0] reg_addr_t;

	// 11-bit channel frequency
	typedef logic [10:0] freq_t;

	// volume, also the width of the output sample
	typedef logic [3:0] vol_t;

	typedef logic [2:0] period_t;
	typedef logic [2:0] shift_t;

	// length count runs from 64 down to 0
	typedef logic [6:0] len_t;

	typedef logic [1:0] duty_t;

	typedef enum logic [1:0] {
		SWEEP_IDLE,
		SWEEP_RUN,
		SWEEP_DEAD
	} sweep_state_t;

endpackage

/* verilog/ch1_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "apu_defines.svh"

module ch1_regs (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               wr,
	input  logic               rd,
	input  apu_pkg::reg_addr_t addr,
	input  apu_pkg::reg_data_t wdata,
	input  logic               freq_wr,
	input  apu_pkg::freq_t     freq_new,
	output apu_pkg::reg_data_t rdata,
	output logic               trigger,
	output logic               length_wr,
	output apu_pkg::period_t   sweep_period,
	output logic               sweep_negate,
	output apu_pkg::shift_t    sweep_shift,
	output apu_pkg::duty_t     duty,
	output logic [5:0]         length_load,
	output apu_pkg::vol_t      env_init,
	output logic               env_up,
	output apu_pkg::period_t   env_period,
	output apu_pkg::freq_t     freq,
	output logic               length_en
);

	apu_pkg::reg_data_t nr10, nr11, nr12, nr13, nr14;

	// ========================================================================
	// write side
	// ========================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			nr10      <= '0;
			nr11      <= '0;
			nr12      <= '0;
			nr13      <= '0;
			nr14      <= '0;
			trigger   <= 1'b0;
			length_wr <= 1'b0;
		end else begin
			if (wr) begin
				case (addr)
					`APU_NR10: nr10 <= wdata;
					`APU_NR11: nr11 <= wdata;
					`APU_NR12: nr12 <= wdata;
					`APU_NR13: nr13 <= wdata;
					`APU_NR14: nr14 <= wdata;
					default: ;
				endcase
			end
			// the sweep unit owns the frequency when it writes back
			if (freq_wr) begin
				nr13      <= freq_new[7:0];
				nr14[2:0] <= freq_new[10:8];
			end
			trigger   <= wr && (addr == `APU_NR14) && wdata[7];
			length_wr <= wr && (addr == `APU_NR11);
		end
	end

	// ========================================================================
	// read side
	// ========================================================================
	always_comb begin
		rdata = '0;
		if (rd) begin
			case (addr)
				`APU_NR10: rdata = nr10 | `APU_NR10_MASK;
				`APU_NR11: rdata = nr11 | `APU_NR11_MASK;
				`APU_NR12: rdata = nr12 | `APU_NR12_MASK;
				`APU_NR13: rdata = nr13 | `APU_NR13_MASK;
				`APU_NR14: rdata = nr14 | `APU_NR14_MASK;
				default:   rdata = 8'hff;
			endcase
		end
	end

	assign sweep_period = nr10[6:4];
	assign sweep_negate = nr10[3];
	assign sweep_shift  = nr10[2:0];
	assign duty         = nr11[7:6];
	assign length_load  = nr11[5:0];
	assign env_init     = nr12[7:4];
	assign env_up       = nr12[3];
	assign env_period   = nr12[2:0];
	assign freq         = {nr14[2:0], nr13};
	assign length_en    = nr14[6];

endmodule

/* verilog/ch1_frame_seq.sv */
`timescale 1ns/1ps
`default_nettype none
`include "apu_defines.svh"

module ch1_frame_seq (
	input  logic clk,
	input  logic rst_n,
	input  logic frame_tick,
	output logic len_tick,
	output logic sweep_tick,
	output logic env_tick
);

	logic [2:0] step;
	logic [2:0] step_next;

	assign step_next = step + 3'd1;

	// ticks are decoded from the step that frame_tick moves to
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step       <= '0;
			len_tick   <= 1'b0;
			sweep_tick <= 1'b0;
			env_tick   <= 1'b0;
		end else begin
			if (frame_tick)
				step <= step_next;
			len_tick   <= frame_tick && !step_next[0];
			sweep_tick <= frame_tick && ((step_next == `APU_STEP_SWEEP_A) ||
			                             (step_next == `APU_STEP_SWEEP_B));
			env_tick   <= frame_tick && (step_next == `APU_STEP_ENV);
		end
	end

endmodule

/* verilog/ch1_sweep.sv */
`timescale 1ns/1ps
`default_nettype none

module ch1_sweep (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             trigger,
	input  logic             sweep_tick,
	input  apu_pkg::period_t sweep_period,
	input  logic             sweep_negate,
	input  apu_pkg::shift_t  sweep_shift,
	input  apu_pkg::freq_t   freq,
	input  logic             active,
	output logic             freq_wr,
	output apu_pkg::freq_t   freq_new,
	output logic             sweep_kill
);

	apu_pkg::sweep_state_t state;
	apu_pkg::freq_t        shadow;
	apu_pkg::period_t      sweep_timer;
	apu_pkg::freq_t        base;
	logic [11:0]           delta;
	logic [11:0]           sum;

	// on trigger the check runs on the register value, later on the shadow copy
	assign base  = trigger ? freq : shadow;
	assign delta = {1'b0, base} >> sweep_shift;
	assign sum   = sweep_negate ? ({1'b0, base} - delta) : ({1'b0, base} + delta);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= apu_pkg::SWEEP_IDLE;
			shadow      <= '0;
			sweep_timer <= '0;
			freq_wr     <= 1'b0;
			freq_new    <= '0;
			sweep_kill  <= 1'b0;
		end else begin
			freq_wr    <= 1'b0;
			sweep_kill <= 1'b0;
			if (trigger) begin
				shadow      <= freq;
				sweep_timer <= sweep_period;
				if ((sweep_shift != 3'd0) && sum[11]) begin
					state      <= apu_pkg::SWEEP_DEAD;
					sweep_kill <= 1'b1;
				end else if ((sweep_period != 3'd0) || (sweep_shift != 3'd0)) begin
					state <= apu_pkg::SWEEP_RUN;
				end else begin
					state <= apu_pkg::SWEEP_IDLE;
				end
			end else if (sweep_tick && active && (state == apu_pkg::SWEEP_RUN)) begin
				if (sweep_timer > 3'd1) begin
					sweep_timer <= sweep_timer - 3'd1;
				end else begin
					sweep_timer <= sweep_period;
					// a zero period reloads the timer but never steps
					if (sweep_period != 3'd0) begin
						if (sum[11]) begin
							state      <= apu_pkg::SWEEP_DEAD;
							sweep_kill <= 1'b1;
						end else if (sweep_shift != 3'd0) begin
							shadow   <= sum[10:0];
							freq_new <= sum[10:0];
							freq_wr  <= 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

/* verilog/ch1_duty_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module ch1_duty_timer (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           trigger,
	input  logic           active,
	input  apu_pkg::freq_t freq,
	input  apu_pkg::duty_t duty,
	output logic           wave
);

	// reload value 2048 - freq needs one bit more than the frequency
	logic [11:0] timer;
	logic [11:0] reload;
	logic [2:0]  step;
	logic [7:0]  pattern;

	assign reload = 12'd2048 - {1'b0, freq};

	// 12.5%, 25%, 50% and 75% duty, one bit per step
	always_comb begin
		case (duty)
			2'd0:    pattern = 8'b0000_0001;
			2'd1:    pattern = 8'b1000_0001;
			2'd2:    pattern = 8'b1000_0111;
			default: pattern = 8'b0111_1110;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer <= '0;
			step  <= '0;
			wave  <= 1'b0;
		end else begin
			if (trigger) begin
				timer <= reload;
			end else if (active) begin
				if (timer <= 12'd1) begin
					timer <= reload;
					step  <= step + 3'd1;
				end else begin
					timer <= timer - 12'd1;
				end
			end
			wave <= pattern[step];
		end
	end

endmodule

/* verilog/ch1_env_len.sv */
`timescale 1ns/1ps
`default_nettype none

module ch1_env_len (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             trigger,
	input  logic             length_wr,
	input  logic [5:0]       length_load,
	input  logic             length_en,
	input  logic             len_tick,
	input  logic             env_tick,
	input  apu_pkg::vol_t    env_init,
	input  logic             env_up,
	input  apu_pkg::period_t env_period,
	input  logic             sweep_kill,
	input  logic             wave,
	output apu_pkg::vol_t    sample,
	output logic             active
);

	apu_pkg::len_t    len_cnt;
	apu_pkg::vol_t    volume;
	apu_pkg::period_t env_timer;
	logic             dac_on;
	logic             len_step;

	// the DAC is off when NR12 bits 7 to 3 are all zero
	assign dac_on   = (env_init != 4'd0) || env_up;
	assign len_step = len_tick && length_en && (len_cnt != 7'd0);

	// ========================================================================
	// length counter and channel enable
	// ========================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			len_cnt <= '0;
			active  <= 1'b0;
		end else begin
			if (length_wr)
				len_cnt <= 7'd64 - {1'b0, length_load};
			else if (trigger && (len_cnt == 7'd0))
				len_cnt <= 7'd64;
			else if (len_step)
				len_cnt <= len_cnt - 7'd1;

			if (trigger)
				active <= dac_on;
			else if (len_step && (len_cnt == 7'd1))
				active <= 1'b0;
			if (sweep_kill || !dac_on)
				active <= 1'b0;
		end
	end

	// ========================================================================
	// envelope and sample output
	// ========================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			volume    <= '0;
			env_timer <= '0;
			sample    <= '0;
		end else begin
			if (trigger) begin
				volume    <= env_init;
				env_timer <= env_period;
			end else if (env_tick && (env_period != 3'd0)) begin
				if (env_timer > 3'd1) begin
					env_timer <= env_timer - 3'd1;
				end else begin
					env_timer <= env_period;
					if (env_up && (volume != 4'd15))
						volume <= volume + 4'd1;
					else if (!env_up && (volume != 4'd0))
						volume <= volume - 4'd1;
				end
			end
			sample <= (active && wave) ? volume : 4'd0;
		end
	end

endmodule

/* verilog/ch1_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ch1_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               wr,
	input  logic               rd,
	input  apu_pkg::reg_addr_t addr,
	input  apu_pkg::reg_data_t wdata,
	input  logic               frame_tick,
	output apu_pkg::reg_data_t rdata,
	output apu_pkg::vol_t      sample,
	output logic               active
);

	// register fields
	logic               trigger;
	logic               length_wr;
	apu_pkg::period_t   sweep_period;
	logic               sweep_negate;
	apu_pkg::shift_t    sweep_shift;
	apu_pkg::duty_t     duty;
	logic [5:0]         length_load;
	apu_pkg::vol_t      env_init;
	logic               env_up;
	apu_pkg::period_t   env_period;
	apu_pkg::freq_t     freq;
	logic               length_en;

	// sweep write-back and kill
	logic               freq_wr;
	apu_pkg::freq_t     freq_new;
	logic               sweep_kill;

	// frame sequencer ticks and waveform
	logic               len_tick;
	logic               sweep_tick;
	logic               env_tick;
	logic               wave;

	// every port name matches its net, so the blocks connect by name
	ch1_regs       u_regs       (.*);
	ch1_frame_seq  u_frame_seq  (.*);
	ch1_sweep      u_sweep      (.*);
	ch1_duty_timer u_duty_timer (.*);
	ch1_env_len    u_env_len    (.*);

endmodule

/* bench/ch1_tb.sv */
`timescale 1ns/1ps
`include "apu_defines.svh"

module ch1_tb;

	localparam int CLK_PERIOD = 4;
	// cycle budget of each test
	// the sweep test waits out several slow duty periods
	localparam int CYC_REGS    = 40;
	localparam int CYC_DUTY    = 4 * 80;
	localparam int CYC_LENGTH  = 8 * 5 + 40;
	localparam int CYC_ENV     = 6 * (8 * 5 + 20) + 40;
	localparam int CYC_SWEEP   = 3 * 8 * 2048 + 200;
	localparam int CYC_DAC     = 100;
	localparam int WATCHDOG_NS = 2 * CLK_PERIOD *
		(CYC_REGS + CYC_DUTY + CYC_LENGTH + CYC_ENV + CYC_SWEEP + CYC_DAC);

	logic               clk;
	logic               rst_n;
	logic               wr;
	logic               rd;
	apu_pkg::reg_addr_t addr;
	apu_pkg::reg_data_t wdata;
	logic               frame_tick;
	apu_pkg::reg_data_t rdata;
	apu_pkg::vol_t      sample;
	logic               active;

	string test_name;
	int    frame_count;

	ch1_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr         (wr),
		.rd         (rd),
		.addr       (addr),
		.wdata      (wdata),
		.frame_tick (frame_tick),
		.rdata      (rdata),
		.sample     (sample),
		.active     (active)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		stop_on_error($sformatf("watchdog expired after %0d ns, test %s is stuck",
			WATCHDOG_NS, test_name));
	end

	// ========================================================================
	// bus, timing and compare helpers
	// ========================================================================
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic tick(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic reg_write(input apu_pkg::reg_addr_t a, input apu_pkg::reg_data_t d);
		wr    = 1'b1;
		addr  = a;
		wdata = d;
		tick(1);
		wr    = 1'b0;
	endtask

	task automatic reg_read(input apu_pkg::reg_addr_t a, output apu_pkg::reg_data_t d);
		rd   = 1'b1;
		addr = a;
		#1;
		d    = rdata;
		tick(1);
		rd   = 1'b0;
	endtask

	// one frame tick, then enough idle cycles for the ticks to take effect
	task automatic frame_pulse();
		frame_tick = 1'b1;
		tick(1);
		frame_tick = 1'b0;
		frame_count++;
		tick(3);
	endtask

	// NR14 is written last with bit 7 set so the channel triggers
	task automatic start_channel(input apu_pkg::reg_data_t nr10, nr11, nr12,
		input apu_pkg::freq_t f, input logic len_en);
		reg_write(`APU_NR10, nr10);
		reg_write(`APU_NR11, nr11);
		reg_write(`APU_NR12, nr12);
		reg_write(`APU_NR13, f[7:0]);
		reg_write(`APU_NR14, {1'b1, len_en, 3'b000, f[10:8]});
	endtask

	task automatic measure_peak(input int cycles, output apu_pkg::vol_t peak);
		peak = 4'd0;
		repeat (cycles) begin
			if (sample > peak)
				peak = sample;
			tick(1);
		end
	endtask

	task automatic wait_sample(input logic level);
		while ((sample != 4'd0) != level)
			tick(1);
	endtask

	function automatic logic pattern_bit(input logic [7:0] pat, input int s);
		logic [7:0] shifted;
		shifted = pat >> (s % 8);
		return shifted[0];
	endfunction

	task automatic check_byte(input string what, input apu_pkg::reg_data_t expected,
		input apu_pkg::reg_data_t actual);
		if (actual !== expected)
			stop_on_error($sformatf("** Error %s (%s): expected %h, got %h",
				test_name, what, expected, actual));
	endtask

	task automatic check_vol(input string what, input apu_pkg::vol_t expected,
		input apu_pkg::vol_t actual);
		if (actual !== expected)
			stop_on_error($sformatf("** Error %s (%s): expected %0d, got %0d",
				test_name, what, expected, actual));
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected)
			stop_on_error($sformatf("** Error %s (%s): expected %b, got %b",
				test_name, what, expected, actual));
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		if (actual != expected)
			stop_on_error($sformatf("** Error %s (%s): expected %0d, got %0d",
				test_name, what, expected, actual));
	endtask

	// ========================================================================
	// directed tests
	// ========================================================================
	task automatic test_readback();
		apu_pkg::reg_data_t written [5];
		apu_pkg::reg_data_t masks [5];
		apu_pkg::reg_data_t got;
		int                 r;
		test_name = "readback";
		masks = '{8'h80, 8'h3f, 8'h00, 8'hff, 8'hbf};
		for (int i = 0; i < 5; i++) begin
			r = $urandom();
			written[i] = r[7:0];
			reg_write(i[2:0], written[i]);
		end
		for (int i = 0; i < 5; i++) begin
			reg_read(i[2:0], got);
			check_byte($sformatf("NR1%0d", i), written[i] | masks[i], got);
		end
		reg_read(3'd5, got);
		check_byte("unused address", 8'hff, got);
		tick(1);
		check_byte("bus without rd", 8'h00, rdata);
	endtask

	task automatic test_duty();
		logic [7:0]    pats [4];
		apu_pkg::vol_t seen [32];
		int            rise;
		int            k;
		test_name = "duty";
		pats = '{8'b0000_0001, 8'b1000_0001, 8'b1000_0111, 8'b0111_1110};
		for (int d = 0; d < 4; d++) begin
			// step where the pattern goes from low to high
			rise = 0;
			for (int s = 0; s < 8; s++)
				if (pattern_bit(pats[d], s) && !pattern_bit(pats[d], s + 7))
					rise = s;
			start_channel(8'h00, {d[1:0], 6'd0}, 8'hf0, 11'd2046, 1'b0);
			tick(2);
			for (int i = 0; i < 32; i++) begin
				seen[i] = sample;
				tick(2);
			end
			k = 1;
			while (k < 16 && !(seen[k - 1] == 4'd0 && seen[k] == 4'd15))
				k++;
			if (k == 16)
				stop_on_error($sformatf("duty %0d never showed a rising sample", d));
			for (int j = 0; j < 16; j++)
				check_vol($sformatf("duty %0d step %0d", d, j),
					pattern_bit(pats[d], rise + j) ? 4'd15 : 4'd0, seen[k + j]);
		end
	endtask

	task automatic test_length();
		int len_seen;
		test_name = "length";
		// duty 2 with length 60 leaves a count of 4
		start_channel(8'h00, 8'hbc, 8'hf0, 11'd1024, 1'b1);
		tick(2);
		check_bit("active after trigger", 1'b1, active);
		len_seen = 0;
		while (len_seen < 3) begin
			frame_pulse();
			if (frame_count % 2 == 0)
				len_seen++;
		end
		check_bit("active after 3 length ticks", 1'b1, active);
		while (len_seen < 4) begin
			frame_pulse();
			if (frame_count % 2 == 0)
				len_seen++;
		end
		check_bit("active after 4 length ticks", 1'b0, active);
	endtask

	task automatic test_envelope();
		apu_pkg::vol_t peak;
		apu_pkg::vol_t expected;
		test_name = "envelope";
		start_channel(8'h00, 8'h80, 8'h41, 11'd2047, 1'b0);
		tick(2);
		expected = 4'd4;
		// eight frame ticks always hold exactly one envelope step
		for (int g = 0; g < 6; g++) begin
			measure_peak(16, peak);
			check_vol($sformatf("peak after %0d envelope steps", g), expected, peak);
			repeat (8)
				frame_pulse();
			if (expected != 4'd0)
				expected = expected - 4'd1;
		end
	endtask

	task automatic test_sweep();
		int sweep_seen;
		int width;
		test_name = "sweep";
		// 2000 plus 1000 overflows on the trigger check
		start_channel(8'h01, 8'h00, 8'hf0, 11'd2000, 1'b0);
		tick(4);
		check_bit("active after overflow", 1'b0, active);
		// period 1 and negate with shift 1 halve the frequency on each step
		start_channel(8'h19, 8'h00, 8'hf0, 11'd512, 1'b0);
		tick(2);
		check_bit("active after trigger", 1'b1, active);
		sweep_seen = 0;
		while (sweep_seen < 2) begin
			frame_pulse();
			if (frame_count % 8 == 2 || frame_count % 8 == 6)
				sweep_seen++;
		end
		// duty 0 is high for one step, so one high pulse is one step
		wait_sample(1'b1);
		wait_sample(1'b0);
		wait_sample(1'b1);
		width = 0;
		while (sample != 4'd0) begin
			tick(1);
			width++;
		end
		check_count("duty step length", 2048 - 128, width);
	endtask

	task automatic test_dac_off();
		apu_pkg::vol_t peak;
		test_name = "dac off";
		// the volume stays at 15 until the next trigger
		start_channel(8'h00, 8'h80, 8'hf0, 11'd2047, 1'b0);
		tick(2);
		measure_peak(16, peak);
		check_vol("sample before the DAC goes off", 4'd15, peak);
		reg_write(`APU_NR12, 8'h00);
		tick(2);
		check_bit("active once the DAC is off", 1'b0, active);
		measure_peak(32, peak);
		check_vol("sample once the DAC is off", 4'd0, peak);
		start_channel(8'h00, 8'h80, 8'h00, 11'd2047, 1'b0);
		tick(2);
		check_bit("active with the DAC off", 1'b0, active);
	endtask

	initial begin
		void'($urandom(32'hfd22_6203));
		test_name   = "reset";
		frame_count = 0;
		rst_n       = 1'b0;
		wr          = 1'b0;
		rd          = 1'b0;
		addr        = '0;
		wdata       = '0;
		frame_tick  = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		tick(1);
		test_readback();
		test_duty();
		test_length();
		test_envelope();
		test_sweep();
		test_dac_off();
		$display("Done: no errors");
		$finish;
	end

endmodule

/* ch1_top.f */
+incdir+include
verilog/apu_pkg.sv
verilog/ch1_regs.sv
verilog/ch1_frame_seq.sv
verilog/ch1_sweep.sv
verilog/ch1_duty_timer.sv
verilog/ch1_env_len.sv
verilog/ch1_top.sv
bench/ch1_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module ch1_tb -f ch1_top.f -o ch1_sim &&
./obj_dir/ch1_sim ||
{ echo "simulation failed"; exit 1; }
